//--- conv_buf_pkg.sv
`default_nettype none

package conv_buf_pkg;

    // activation lanes written per buffer row
    localparam int hw_d1 = 4;
    localparam int lane_idx_w = $clog2(hw_d1);

    // fill row counter and read offset widths
    localparam int fill_row_w = 11;
    localparam int act_rd_cnt_w = 12;
    localparam int pbuf_addr_w = 12;

    typedef logic [hw_d1-1:0] lane_en_t;
    typedef logic [lane_idx_w-1:0] lane_idx_t;
    typedef logic [fill_row_w-1:0] fill_row_t;

    // half select on top, row below
    typedef logic [fill_row_w:0] act_wr_addrh_t;

    typedef logic [act_rd_cnt_w-1:0] act_rd_cnt_t;
    typedef logic [act_rd_cnt_w:0] act_rd_addr_t;
    typedef logic [pbuf_addr_w-1:0] pbuf_addr_t;

    // arithmetic pipeline depth from psum read to psum write
    localparam int pbuf_wr_addr_delay = 4 + (hw_d1 + 1) / 2 + 1;
    // write enable lags one more cycle than the address
    localparam int pbuf_wr_en_delay = pbuf_wr_addr_delay + 1;

endpackage

`default_nettype wire

//--- conv_loop_pkg.sv
`default_nettype none

package conv_loop_pkg;

    localparam int t_field_w = 4;
    localparam int loop_levels = 5;

    typedef logic [t_field_w-1:0] t_field_t;
    typedef logic [loop_levels*t_field_w-1:0] temp_param_t;

    // t0 sits in the low nibble of temp_param
    typedef struct packed {
        t_field_t t4;
        t_field_t t3;
        t_field_t t2;
        t_field_t t1;
        t_field_t t0;
    } loop_cfg_t;

    // current loop indices, i0 steps by two
    typedef struct packed {
        t_field_t i4;
        t_field_t i3;
        t_field_t i2;
        t_field_t i1;
        t_field_t i0;
    } loop_idx_t;

    typedef enum logic [1:0] {
        both_busy,
        fill_done,
        calc_done,
        swap
    } swap_state_t;

endpackage

`default_nettype wire

//--- buf_swap_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module buf_swap_fsm import conv_loop_pkg::*; (
    input  wire  clk_l,
    input  wire  rst_n,
    input  wire  fill_finish,
    input  wire  calc_finish,
    output logic updt_busy,
    output logic calc_busy,
    output logic updt_sel,
    output logic calc_sel
);

    swap_state_t state;
    swap_state_t state_nxt;
    logic        swap_cond;

    // busy flags follow directly from the state
    assign updt_busy = (state != fill_done);
    assign calc_busy = (state != calc_done);

    // both sides done, either together or one waiting on the other
    assign swap_cond = (fill_finish & calc_finish) |
                       (fill_finish & ~calc_busy) |
                       (calc_finish & ~updt_busy);

    always_comb begin
        state_nxt = state;
        if (swap_cond) begin
            state_nxt = swap;
        end else begin
            case (state)
                both_busy: begin
                    if (fill_finish) begin
                        state_nxt = fill_done;
                    end else if (calc_finish) begin
                        state_nxt = calc_done;
                    end
                end
                swap:    state_nxt = both_busy;
                default: state_nxt = state;
            endcase
        end
    end

    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            // start with the fill half loading and calc idle
            state    <= calc_done;
            updt_sel <= 1'b0;
            calc_sel <= 1'b1;
        end else begin
            state <= state_nxt;
            // halves trade places on the way out of swap
            if (state == swap) begin
                updt_sel <= ~updt_sel;
                calc_sel <= ~calc_sel;
            end
        end
    end

endmodule

`default_nettype wire

//--- act_fill_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module act_fill_ctrl import conv_buf_pkg::*, conv_loop_pkg::*; (
    input  wire            clk_l,
    input  wire            rst_n,
    input  wire loop_cfg_t cfg,
    input  wire            updt_busy,
    input  wire            updt_sel,
    input  wire            act_wr_vld,
    output logic           act_wr_req,
    output lane_en_t       act_wr_en,
    output act_wr_addrh_t  act_wr_addrh,
    output logic           fill_finish
);

    logic [12:0] cap_prod;
    fill_row_t   cap;
    lane_idx_t   lane_cnt;
    fill_row_t   row_cnt;
    logic        beat;
    logic        lane_last;
    logic        row_last;

    // rows per fill pass, two activations packed per row
    assign cap_prod = (13'(cfg.t2) + 13'd1) * (13'(cfg.t0) + 13'd1) * (13'(cfg.t1) + 13'd1);

    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            cap <= '0;
        end else begin
            cap <= fill_row_t'(cap_prod >> 1);
        end
    end

    // a beat is taken whenever valid meets an open request
    assign beat      = act_wr_vld & act_wr_req;
    assign lane_last = (lane_cnt == lane_idx_t'(hw_d1 - 1));
    assign row_last  = (row_cnt == cap - fill_row_t'(1));

    assign fill_finish  = beat & lane_last & row_last;
    assign act_wr_en    = beat ? (lane_en_t'(1) << lane_cnt) : '0;
    assign act_wr_addrh = {updt_sel, row_cnt};

    // lane steps every beat, row steps when the lane wraps
    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            lane_cnt <= '0;
            row_cnt  <= '0;
        end else if (beat) begin
            lane_cnt <= lane_last ? '0 : lane_cnt + lane_idx_t'(1);
            if (lane_last) begin
                row_cnt <= row_last ? '0 : row_cnt + fill_row_t'(1);
            end
        end
    end

    // request rises one cycle after busy, drops after the last beat
    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            act_wr_req <= 1'b0;
        end else if (updt_busy) begin
            act_wr_req <= 1'b1;
            if (fill_finish) begin
                act_wr_req <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- loop_nest.sv
`timescale 1ns/100ps
`default_nettype none

module loop_nest import conv_loop_pkg::*; (
    input  wire              clk_l,
    input  wire              rst_n,
    input  wire temp_param_t temp_param,
    input  wire              temp_param_en,
    input  wire              calc_busy,
    output loop_cfg_t        cfg,
    output loop_idx_t        idx,
    output logic             calc_run,
    output logic             calc_finish
);

    logic wrap0;
    logic wrap1;
    logic wrap2;
    logic wrap3;
    logic wrap4;
    logic en1;
    logic en2;
    logic en3;
    logic en4;

    // loop bounds, only reloaded between fills
    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= '0;
        end else if (temp_param_en) begin
            cfg <= loop_cfg_t'(temp_param);
        end
    end

    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            calc_run <= 1'b0;
        end else if (calc_busy) begin
            calc_run <= 1'b1;
            if (calc_finish) begin
                calc_run <= 1'b0;
            end
        end
    end

    // last value of each level, i0 walks even positions only
    assign wrap0 = (idx.i0 == cfg.t0 - t_field_t'(2));
    assign wrap1 = (idx.i1 == cfg.t1 - t_field_t'(1));
    assign wrap2 = (idx.i2 == cfg.t2 - t_field_t'(1));
    assign wrap3 = (idx.i3 == cfg.t3 - t_field_t'(1));
    assign wrap4 = (idx.i4 == cfg.t4 - t_field_t'(1));

    // each level advances when the one below wraps
    assign en1 = calc_run & wrap0;
    assign en2 = en1 & wrap1;
    assign en3 = en2 & wrap2;
    assign en4 = en3 & wrap3;

    // level 4 stepping marks the end of one pass
    assign calc_finish = en4;

    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            idx <= '0;
        end else begin
            if (calc_run) idx.i0 <= wrap0 ? '0 : idx.i0 + t_field_t'(2);
            if (en1)      idx.i1 <= wrap1 ? '0 : idx.i1 + t_field_t'(1);
            if (en2)      idx.i2 <= wrap2 ? '0 : idx.i2 + t_field_t'(1);
            if (en3)      idx.i3 <= wrap3 ? '0 : idx.i3 + t_field_t'(1);
            if (en4)      idx.i4 <= wrap4 ? '0 : idx.i4 + t_field_t'(1);
        end
    end

endmodule

`default_nettype wire

//--- buf_addr_gen.sv
`timescale 1ns/100ps
`default_nettype none

module buf_addr_gen import conv_buf_pkg::*, conv_loop_pkg::*; (
    input  wire            clk_l,
    input  wire            rst_n,
    input  wire loop_cfg_t cfg,
    input  wire loop_idx_t idx,
    input  wire            calc_run,
    input  wire            calc_sel,
    output act_rd_addr_t   act_rd_addr,
    output pbuf_addr_t     pbuf_rd_addr,
    output pbuf_addr_t     pbuf_wr_addr,
    output logic           pbuf_wr_en
);

    act_rd_cnt_t plane;
    act_rd_cnt_t row_off;
    act_rd_cnt_t act_rd_cnt;
    logic        calc_sel_d;
    pbuf_addr_t  addr_pipe [pbuf_wr_addr_delay];
    logic [pbuf_wr_en_delay-1:0] run_pipe;

    // offset shared by both address streams
    assign plane   = act_rd_cnt_t'(cfg.t0) * act_rd_cnt_t'(cfg.t1);
    assign row_off = act_rd_cnt_t'(idx.i0) * act_rd_cnt_t'(cfg.t1) + act_rd_cnt_t'(idx.i1);

    always_ff @(posedge clk_l) begin
        act_rd_cnt   <= act_rd_cnt_t'(idx.i2) * plane + row_off;
        pbuf_rd_addr <= pbuf_addr_t'(act_rd_cnt_t'(idx.i3) * plane + row_off);
    end

    // select lines up with the registered offset
    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            calc_sel_d <= 1'b1;
        end else begin
            calc_sel_d <= calc_sel;
        end
    end

    assign act_rd_addr = {calc_sel_d, act_rd_cnt};

    // psum write address trails the read through the MAC pipeline
    always_ff @(posedge clk_l) begin
        addr_pipe[0] <= pbuf_rd_addr;
        for (int k = 1; k < pbuf_wr_addr_delay; k++) begin
            addr_pipe[k] <= addr_pipe[k-1];
        end
    end

    assign pbuf_wr_addr = addr_pipe[pbuf_wr_addr_delay-1];

    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            run_pipe <= '0;
        end else begin
            run_pipe <= {run_pipe[pbuf_wr_en_delay-2:0], calc_run};
        end
    end

    assign pbuf_wr_en = run_pipe[pbuf_wr_en_delay-1];

endmodule

`default_nettype wire

//--- conv_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module conv_ctrl_top import conv_buf_pkg::*, conv_loop_pkg::*; (
    input  wire              clk_l,
    input  wire              rst_n,
    input  wire temp_param_t temp_param,
    input  wire              temp_param_en,
    input  wire              act_wr_vld,
    output logic             act_wr_req,
    output lane_en_t         act_wr_en,
    output act_wr_addrh_t    act_wr_addrh,
    output act_rd_addr_t     act_rd_addr,
    output pbuf_addr_t       pbuf_rd_addr,
    output pbuf_addr_t       pbuf_wr_addr,
    output logic             pbuf_wr_en
);

    loop_cfg_t cfg;
    loop_idx_t idx;
    logic      calc_run;
    logic      fill_finish;
    logic      calc_finish;
    logic      updt_busy;
    logic      calc_busy;
    logic      updt_sel;
    logic      calc_sel;

    buf_swap_fsm buf_swap_fsm_inst (
        .clk_l       (clk_l),
        .rst_n       (rst_n),
        .fill_finish (fill_finish),
        .calc_finish (calc_finish),
        .updt_busy   (updt_busy),
        .calc_busy   (calc_busy),
        .updt_sel    (updt_sel),
        .calc_sel    (calc_sel)
    );

    act_fill_ctrl act_fill_ctrl_inst (
        .clk_l        (clk_l),
        .rst_n        (rst_n),
        .cfg          (cfg),
        .updt_busy    (updt_busy),
        .updt_sel     (updt_sel),
        .act_wr_vld   (act_wr_vld),
        .act_wr_req   (act_wr_req),
        .act_wr_en    (act_wr_en),
        .act_wr_addrh (act_wr_addrh),
        .fill_finish  (fill_finish)
    );

    loop_nest loop_nest_inst (
        .clk_l         (clk_l),
        .rst_n         (rst_n),
        .temp_param    (temp_param),
        .temp_param_en (temp_param_en),
        .calc_busy     (calc_busy),
        .cfg           (cfg),
        .idx           (idx),
        .calc_run      (calc_run),
        .calc_finish   (calc_finish)
    );

    buf_addr_gen buf_addr_gen_inst (
        .clk_l        (clk_l),
        .rst_n        (rst_n),
        .cfg          (cfg),
        .idx          (idx),
        .calc_run     (calc_run),
        .calc_sel     (calc_sel),
        .act_rd_addr  (act_rd_addr),
        .pbuf_rd_addr (pbuf_rd_addr),
        .pbuf_wr_addr (pbuf_wr_addr),
        .pbuf_wr_en   (pbuf_wr_en)
    );

endmodule

`default_nettype wire

//--- conv_ctrl_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module conv_ctrl_asserts import conv_buf_pkg::*, conv_loop_pkg::*; (
    input wire                clk_l,
    input wire                rst_n,
    input wire temp_param_t   temp_param,
    input wire                temp_param_en,
    input wire                act_wr_vld,
    input wire                act_wr_req,
    input wire lane_en_t      act_wr_en,
    input wire act_wr_addrh_t act_wr_addrh,
    input wire act_rd_addr_t  act_rd_addr,
    input wire pbuf_addr_t    pbuf_rd_addr,
    input wire pbuf_addr_t    pbuf_wr_addr,
    input wire                pbuf_wr_en
);

    int          fail_cnt = 0;
    loop_cfg_t   cfg_m;
    int          beat_cnt;
    int          run_len;
    int          warm;
    int          cap_m;
    int          pass_len;
    int          half_t0;
    int          i0_m;
    int          i1_m;
    int          i2_m;
    int          i3_m;
    logic        fill_pending;
    logic        wr_sel_d;
    logic        rd_sel_d;
    logic        beat;
    logic        fill_end;
    logic        wr_sel;
    logic        rd_sel;
    logic        wr_tog;
    logic        rd_tog;
    lane_en_t    lane_exp;
    fill_row_t   row_exp;
    fill_row_t   wr_row;
    act_rd_cnt_t off_exp;
    act_rd_cnt_t act_rd_off;
    pbuf_addr_t  psum_exp;

    task automatic count_failure(input string msg);
        $error("%s", msg);
        fail_cnt++;
    endtask

    // fill side of the model
    assign cap_m    = ((int'(cfg_m.t2) + 1) * (int'(cfg_m.t0) + 1) * (int'(cfg_m.t1) + 1)) / 2;
    assign beat     = act_wr_vld & act_wr_req;
    assign fill_end = beat && (beat_cnt == hw_d1 * cap_m - 1);
    assign lane_exp = beat ? lane_en_t'(1 << (beat_cnt % hw_d1)) : '0;
    assign row_exp  = fill_row_t'(beat_cnt / hw_d1);
    assign wr_row   = act_wr_addrh[fill_row_w-1:0];

    // position in the calc pass is the length of the write run so far
    assign half_t0    = int'(cfg_m.t0) / 2;
    assign pass_len   = half_t0 * int'(cfg_m.t1) * int'(cfg_m.t2) * int'(cfg_m.t3);
    assign i0_m       = 2 * (run_len % half_t0);
    assign i1_m       = (run_len / half_t0) % int'(cfg_m.t1);
    assign i2_m       = (run_len / (half_t0 * int'(cfg_m.t1))) % int'(cfg_m.t2);
    assign i3_m       = (run_len / (half_t0 * int'(cfg_m.t1) * int'(cfg_m.t2))) %
                        int'(cfg_m.t3);
    assign off_exp    = act_rd_cnt_t'(i2_m * int'(cfg_m.t0) * int'(cfg_m.t1) +
                                      i0_m * int'(cfg_m.t1) + i1_m);
    assign psum_exp   = pbuf_addr_t'(i3_m * int'(cfg_m.t0) * int'(cfg_m.t1) +
                                     i0_m * int'(cfg_m.t1) + i1_m);
    assign act_rd_off = act_rd_addr[act_rd_cnt_w-1:0];

    assign wr_sel = act_wr_addrh[fill_row_w];
    assign rd_sel = act_rd_addr[act_rd_cnt_w];
    assign wr_tog = wr_sel != wr_sel_d;
    assign rd_tog = rd_sel != rd_sel_d;

    always_ff @(posedge clk_l or negedge rst_n) begin
        if (!rst_n) begin
            cfg_m        <= '0;
            beat_cnt     <= 0;
            run_len      <= 0;
            warm         <= 0;
            fill_pending <= 1'b0;
            wr_sel_d     <= 1'b0;
            rd_sel_d     <= 1'b1;
        end else begin
            if (temp_param_en) begin
                cfg_m <= loop_cfg_t'(temp_param);
            end
            if (warm < 8) begin
                warm <= warm + 1;
            end
            if (beat) begin
                beat_cnt <= fill_end ? 0 : beat_cnt + 1;
            end
            // a finished fill is owed exactly one swap
            if (fill_end) begin
                fill_pending <= 1'b1;
            end else if (wr_tog) begin
                fill_pending <= 1'b0;
            end
            run_len  <= pbuf_wr_en ? run_len + 1 : 0;
            wr_sel_d <= wr_sel;
            rd_sel_d <= rd_sel;
        end
    end

    a_reset: assert property (@(posedge clk_l)
        !rst_n |-> !act_wr_req && !pbuf_wr_en && act_wr_en == '0)
        else count_failure("request, write enable or lane enable active during reset");

    a_lane: assert property (@(posedge clk_l) disable iff (!rst_n)
        act_wr_en == lane_exp)
        else count_failure($sformatf("Fail %0t act_wr_en got %h exp %h",
                                     $time, act_wr_en, lane_exp));

    a_row: assert property (@(posedge clk_l) disable iff (!rst_n)
        beat |-> wr_row == row_exp)
        else count_failure($sformatf("Fail %0t act_wr_addrh row got %0d exp %0d",
                                     $time, wr_row, row_exp));

    // request drops right after the last beat and at no other time
    a_req_end: assert property (@(posedge clk_l) disable iff (!rst_n || warm < 2)
        $fell(act_wr_req) == $past(fill_end))
        else count_failure($sformatf("Fail %0t act_wr_req fell got %b exp %b",
                                     $time, $fell(act_wr_req), $past(fill_end)));

    a_read: assert property (@(posedge clk_l) disable iff (!rst_n || warm < 8)
        pbuf_wr_en |-> $past(act_rd_off, 7) == off_exp)
        else count_failure($sformatf("Fail %0t act_rd_addr offset got %0d exp %0d",
                                     $time, $past(act_rd_off, 7), off_exp));

    a_pbuf_addr: assert property (@(posedge clk_l) disable iff (!rst_n || warm < 8)
        pbuf_wr_addr == $past(pbuf_rd_addr, 7))
        else count_failure($sformatf("Fail %0t pbuf_wr_addr got %h exp %h",
                                     $time, pbuf_wr_addr, $past(pbuf_rd_addr, 7)));

    // write address carries the psum address of the same pass position
    a_psum_addr: assert property (@(posedge clk_l) disable iff (!rst_n || warm < 8)
        pbuf_wr_en |-> pbuf_wr_addr == psum_exp)
        else count_failure($sformatf("Fail %0t pbuf_wr_addr got %0d exp %0d",
                                     $time, pbuf_wr_addr, psum_exp));

    a_run_len: assert property (@(posedge clk_l) disable iff (!rst_n)
        !pbuf_wr_en && run_len != 0 |-> run_len == pass_len)
        else count_failure($sformatf("Fail %0t pbuf_wr_en run got %0d exp %0d",
                                     $time, run_len, pass_len));

    a_sel_pair: assert property (@(posedge clk_l) disable iff (!rst_n || warm < 2)
        rd_tog == $past(wr_tog))
        else count_failure($sformatf("Fail %0t act_rd_addr select toggle got %b exp %b",
                                     $time, rd_tog, $past(wr_tog)));

    a_sel_differ: assert property (@(posedge clk_l) disable iff (!rst_n)
        !wr_tog |-> wr_sel != rd_sel)
        else count_failure("fill and calc halves point at the same buffer");

    a_swap_once: assert property (@(posedge clk_l) disable iff (!rst_n)
        wr_tog |-> fill_pending)
        else count_failure("fill half swapped without a finished fill pass");

endmodule

bind conv_ctrl_top conv_ctrl_asserts conv_ctrl_asserts_inst (
    .clk_l         (clk_l),
    .rst_n         (rst_n),
    .temp_param    (temp_param),
    .temp_param_en (temp_param_en),
    .act_wr_vld    (act_wr_vld),
    .act_wr_req    (act_wr_req),
    .act_wr_en     (act_wr_en),
    .act_wr_addrh  (act_wr_addrh),
    .act_rd_addr   (act_rd_addr),
    .pbuf_rd_addr  (pbuf_rd_addr),
    .pbuf_wr_addr  (pbuf_wr_addr),
    .pbuf_wr_en    (pbuf_wr_en)
);

`default_nettype wire

//--- tb_conv_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tb_conv_ctrl import conv_buf_pkg::*, conv_loop_pkg::*; ();

    function automatic int fill_beats(input loop_cfg_t c);
        // rows hold two activations, hw_d1 lanes per row
        return hw_d1 * ((int'(c.t2) + 1) * (int'(c.t0) + 1) * (int'(c.t1) + 1) / 2);
    endfunction

    localparam loop_cfg_t cfg_a = '{t4: 4'd1, t3: 4'd2, t2: 4'd2, t1: 4'd2, t0: 4'd4};
    localparam loop_cfg_t cfg_b = '{t4: 4'd2, t3: 4'd2, t2: 4'd3, t1: 4'd3, t0: 4'd2};

    // fill passes dominate, three with cfg_a and two with cfg_b
    localparam int max_cycles = 4 * (3 * fill_beats(cfg_a) + 2 * fill_beats(cfg_b)) + 200;

    logic          clk_l;
    logic          rst_n;
    temp_param_t   temp_param;
    logic          temp_param_en;
    logic          act_wr_vld;
    logic          act_wr_req;
    lane_en_t      act_wr_en;
    act_wr_addrh_t act_wr_addrh;
    act_rd_addr_t  act_rd_addr;
    pbuf_addr_t    pbuf_rd_addr;
    pbuf_addr_t    pbuf_wr_addr;
    logic          pbuf_wr_en;

    int   seed;
    int   swaps;
    int   errors;
    int   cycles = 0;
    logic fill_sel;

    conv_ctrl_top conv_ctrl_top_inst (
        .clk_l         (clk_l),
        .rst_n         (rst_n),
        .temp_param    (temp_param),
        .temp_param_en (temp_param_en),
        .act_wr_vld    (act_wr_vld),
        .act_wr_req    (act_wr_req),
        .act_wr_en     (act_wr_en),
        .act_wr_addrh  (act_wr_addrh),
        .act_rd_addr   (act_rd_addr),
        .pbuf_rd_addr  (pbuf_rd_addr),
        .pbuf_wr_addr  (pbuf_wr_addr),
        .pbuf_wr_en    (pbuf_wr_en)
    );

    initial begin
        clk_l = 1'b0;
        forever #4 clk_l = ~clk_l;
    end

    always @(posedge clk_l) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic load_cfg(input loop_cfg_t c);
        temp_param    = temp_param_t'(c);
        temp_param_en = 1'b1;
        @(posedge clk_l);
        #1;
        temp_param_en = 1'b0;
        // cap is registered one cycle after cfg
        @(posedge clk_l);
        #1;
    endtask

    // random valid beats until the fill half has swapped target times
    task automatic drive_fill(input int target);
        int rnd;
        while (swaps < target) begin
            @(posedge clk_l);
            #1;
            if (act_wr_addrh[fill_row_w] != fill_sel) begin
                fill_sel = act_wr_addrh[fill_row_w];
                swaps++;
            end
            rnd        = $random(seed);
            act_wr_vld = (swaps < target) ? rnd[0] : 1'b0;
        end
    endtask

    // one psum write run covers a whole calculation pass
    task automatic wait_calc_end();
        do begin
            @(posedge clk_l);
            #1;
        end while (!pbuf_wr_en);
        do begin
            @(posedge clk_l);
            #1;
        end while (pbuf_wr_en);
    endtask

    initial begin
        seed          = 91568;
        swaps         = 0;
        fill_sel      = 1'b0;
        rst_n         = 1'b0;
        temp_param    = '0;
        temp_param_en = 1'b0;
        act_wr_vld    = 1'b0;
        repeat (4) @(posedge clk_l);
        #1;
        rst_n = 1'b1;

        load_cfg(cfg_a);
        drive_fill(3);
        // reload only once calc is idle and no beat is pending
        wait_calc_end();
        load_cfg(cfg_b);
        drive_fill(5);
        wait_calc_end();
        repeat (4) @(posedge clk_l);

        errors = conv_ctrl_top_inst.conv_ctrl_asserts_inst.fail_cnt;
        $display("assertion failures: %0d", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
conv_buf_pkg.sv
conv_loop_pkg.sv
buf_swap_fsm.sv
act_fill_ctrl.sv
loop_nest.sv
buf_addr_gen.sv
conv_ctrl_top.sv
conv_ctrl_asserts.sv
tb_conv_ctrl.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = tb_conv_ctrl
FILELIST  = files.f
OBJ_DIR   = obj_dir
RUNARGS   = +verilator+error+limit+1000
PASS_MSG  = NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUNARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
